/* verilog.f */
+incdir+.
cpuIsaPkg.sv
cpuCtrlPkg.sv
cpuRegFile.sv
cpuAlu.sv
cpuControl.sv
cpuExcUnit.sv
cpuCore.sv
cpuCore_sva.sv
tbClock.sv
tbCpuCore.sv

/* run.sh */
#!/bin/sh
# build and run the cpuCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tbCpuCore -o simCpuCore

if ! ./obj_dir/simCpuCore +verilator+error+limit+100 > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -qx "tests failed" sim.log; then
    exit 1
fi

/* tbCpuCore.sv */
// program rom holds 128 words and the data memory 256 words, only the low address bits decode
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tbCpuCore;
    import cpuIsaPkg::*;

    localparam logic [31:0] immA    = 32'h0000_00f3;
    localparam logic [31:0] upper   = 32'h8000_0000;   // lui 0x8000
    localparam logic [31:0] immC    = 32'hffff_fff0;   // addiu 0xfff0 sign extended
    localparam logic [31:0] dmBase  = 32'h0000_0040;
    localparam logic [31:0] dmOffset = 32'h0000_0008;
    localparam logic [31:0] trapPc  = 32'h0000_0054;   // word 21
    localparam logic [31:0] endPc   = 32'h0000_0064;   // word 25, self loop

    logic        clk;
    logic        rstN;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic [31:0] imAddr;
    logic [31:0] imData;
    logic [31:0] dmAddr;
    logic        dmWe;
    logic [31:0] dmWData;
    logic        dmValid;
    logic        dmReady = 1'b0;
    logic [31:0] dmRData = '0;

    logic [31:0] rom [128];
    logic [6:0]  romPtr;
    logic [31:0] dmem [256];
    logic [31:0] reqAddr;
    logic        reqWe;
    logic [31:0] reqData;
    int          waitCnt;
    int          respDelay;
    int          seed = 32'h9072_7665;
    int          mismatches = 0;
    int          addrErrors = 0;
    int          timeouts = 0;

    tbClock i_tbClock (.clk(clk), .rstN(rstN));

    cpuCore i_cpuCore (
        .clk     (clk),
        .rstN    (rstN),
        .regAddr (regAddr),
        .regData (regData),
        .imAddr  (imAddr),
        .imData  (imData),
        .dmAddr  (dmAddr),
        .dmWe    (dmWe),
        .dmWData (dmWData),
        .dmValid (dmValid),
        .dmReady (dmReady),
        .dmRData (dmRData)
    );

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] shamt,
                                          input logic [5:0] fn);
        return {OP_SPEC, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] cop0Op(input logic [4:0] sub, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {OP_COP0, sub, rt, rd, 5'd0, fn};
    endfunction

    task automatic putWord(input logic [31:0] word);
        rom[romPtr] = word;
        romPtr = romPtr + 7'd1;
    endtask

    assign imData = rom[imAddr[6:0]];   // combinational fetch

    initial begin
        // unused words trap with their own index in the low half
        for (int i = 0; i < 128; i++) rom[7'(i)] = iType(6'h3f, 5'd0, 5'd0, 16'(i));
        romPtr = 7'd0;
        putWord(iType(OP_ADDIU, 5'd0, 5'd1, 16'h00f3));
        putWord(iType(OP_LUI, 5'd0, 5'd2, 16'h8000));
        putWord(iType(OP_ADDIU, 5'd0, 5'd5, 16'hfff0));
        putWord(rType(5'd1, 5'd2, 5'd3, 5'd0, F_ADDU));
        putWord(rType(5'd1, 5'd5, 5'd4, 5'd0, F_OR));
        putWord(rType(5'd0, 5'd2, 5'd6, 5'd4, F_SRL));
        putWord(rType(5'd1, 5'd2, 5'd7, 5'd0, F_SLTU));
        putWord(rType(5'd1, 5'd5, 5'd8, 5'd0, F_SUBU));
        putWord(iType(OP_ADDIU, 5'd0, 5'd9, dmBase[15:0]));
        putWord(iType(OP_SW, 5'd9, 5'd3, dmOffset[15:0]));
        putWord(iType(OP_LW, 5'd9, 5'd10, dmOffset[15:0]));
        putWord(iType(OP_ADDIU, 5'd0, 5'd11, 16'h005a));  // sentinel
        putWord(iType(OP_ADDIU, 5'd0, 5'd14, 16'h003c));
        putWord(iType(OP_BEQ, 5'd1, 5'd1, 16'd1));         // taken
        putWord(iType(OP_ADDIU, 5'd0, 5'd11, 16'h0055));
        putWord(iType(OP_BNE, 5'd1, 5'd1, 16'd1));         // falls through
        putWord(iType(OP_ADDIU, 5'd0, 5'd12, 16'h0066));
        putWord(iType(OP_BNE, 5'd1, 5'd2, 16'd1));         // taken
        putWord(iType(OP_ADDIU, 5'd0, 5'd11, 16'h0077));
        putWord(iType(OP_BEQ, 5'd1, 5'd2, 16'd1));         // falls through
        putWord(iType(OP_ADDIU, 5'd0, 5'd13, 16'h0011));
        putWord(iType(6'h3f, 5'd0, 5'd14, 16'h5555));      // reserved, would hit r14
        putWord(iType(OP_ADDIU, 5'd0, 5'd15, 16'h0022));
        putWord(cop0Op(C0_MT, 5'd1, 5'd12, 6'h00));
        putWord(cop0Op(C0_MF, 5'd17, 5'd12, 6'h00));
        putWord(iType(OP_BEQ, 5'd0, 5'd0, 16'hffff));
        // handler: skip the bad word and return
        romPtr = 7'(`CPU_EXC_HANDLER >> 2);
        putWord(cop0Op(C0_MF, 5'd18, 5'd14, 6'h00));
        putWord(iType(OP_ADDIU, 5'd18, 5'd18, 16'd4));
        putWord(cop0Op(C0_MT, 5'd18, 5'd14, 6'h00));
        putWord(iType(OP_ADDIU, 5'd0, 5'd16, 16'h0001));
        putWord(cop0Op(C0_CO, 5'd0, 5'd0, F_ERET));
    end

    // data memory, ready comes 1 to 4 cycles after the request
    always @(posedge clk) begin
        if (!rstN) begin
            dmReady <= 1'b0;
            waitCnt <= 0;
            for (int i = 0; i < 256; i++) dmem[8'(i)] <= 32'hdead_0000 ^ i;
        end else begin
            dmReady <= 1'b0;
            if (dmValid) begin
                assert (dmAddr == dmBase + dmOffset) else begin
                    $display("mismatch at %0t: dmAddr %h, expected %h", $time, dmAddr,
                             dmBase + dmOffset);
                    addrErrors++;
                end
                respDelay = $random(seed) & 3;
                if (respDelay == 0) begin   // answer in the very next cycle
                    dmReady <= 1'b1;
                    dmRData <= dmem[dmAddr[9:2]];
                    if (dmWe) dmem[dmAddr[9:2]] <= dmWData;
                end
                reqAddr <= dmAddr;
                reqWe   <= dmWe;
                reqData <= dmWData;
                waitCnt <= respDelay;
            end else if (waitCnt == 1) begin
                dmReady <= 1'b1;
                dmRData <= dmem[reqAddr[9:2]];
                if (reqWe) dmem[reqAddr[9:2]] <= reqData;
                waitCnt <= 0;
            end else if (waitCnt != 0) begin
                waitCnt <= waitCnt - 1;
            end
        end
    end

    task automatic waitForPc(input logic [31:0] target, input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        regAddr <= 5'd0;
        @(negedge clk);
        while (regData !== target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (regData !== target) begin
            $display("timeout: pc did not reach %h within %0d cycles", target, limit);
            timeouts++;
        end
    endtask

    task automatic checkReg(input logic [4:0] num, input logic [31:0] expected,
                            input string what);
        @(posedge clk);
        regAddr <= num;
        @(negedge clk);
        assert (regData == expected) else begin
            $display("mismatch at %0t: %s, r%0d is %h, expected %h", $time, what, num,
                     regData, expected);
            mismatches++;
        end
    endtask

    initial begin
        int cycles;
        int svaFails;
        int total;
        regAddr = 5'd0;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            $display("timeout: reset was never released");
            timeouts++;
        end else begin
            waitForPc(endPc, 2000);
        end
        if (timeouts == 0) begin
            checkReg(5'd0, endPc, "debug pc");
            checkReg(5'd1, immA, "addiu");
            checkReg(5'd2, upper, "lui");
            checkReg(5'd3, immA + upper, "addu");
            checkReg(5'd4, immA | immC, "or");
            checkReg(5'd5, immC, "addiu sign extension");
            checkReg(5'd6, upper >> 4, "srl");
            checkReg(5'd7, {31'd0, immA < upper}, "sltu");
            checkReg(5'd8, immA - immC, "subu");
            checkReg(5'd10, immA + upper, "lw after sw");
            checkReg(5'd11, 32'h5a, "skipped addiu");
            checkReg(5'd12, 32'h66, "bne not taken");
            checkReg(5'd13, 32'h11, "beq not taken");
            checkReg(5'd14, 32'h3c, "trapping word");
            checkReg(5'd15, 32'h22, "resume after eret");
            checkReg(5'd16, 32'h1, "handler marker");
            checkReg(5'd17, immA, "scratch round trip");
            checkReg(5'd18, trapPc + 32'd4, "epc plus 4");
        end
        svaFails = i_cpuCore.i_cpuCoreSva.validFails + i_cpuCore.i_cpuCoreSva.stallFails +
                   i_cpuCore.i_cpuCoreSva.resetFails;
        total = mismatches + addrErrors + timeouts + svaFails;
        $display("done: %0d register mismatches, %0d address mismatches, %0d timeouts, %0d %s",
                 mismatches, addrErrors, timeouts, svaFails, "assertion failures");
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tbClock.sv */
// free running 4 ns clock and a synchronous active low reset held for the first 16 rising edges
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;   // released on a rising edge
    end

endmodule

/* cpuCore_sva.sv */
// bound into every cpuCore and needs the internal memWait flop, counters only grow on a failure
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuCoreSva (
    input logic                 clk,
    input logic                 rstN,
    input logic                 dmValid,
    input logic                 dmWe,
    input logic                 dmReady,
    input logic                 memWait,
    input logic [`CPU_XLEN-1:0] pc
);
    int validFails = 0;
    int stallFails = 0;
    int resetFails = 0;

    // request is a single cycle pulse
    validPulse: assert property (@(posedge clk) disable iff (!rstN) dmValid |=> !dmValid)
        else begin
            $error("dmValid stayed high for a second cycle");
            validFails++;
        end

    // pc frozen from the issue cycle until ready
    pcHold: assert property (@(posedge clk) disable iff (!rstN)
        (dmValid || (memWait && !dmReady)) |=> $stable(pc))
        else begin
            $error("pc moved while a data memory access was pending");
            stallFails++;
        end

    resetQuiet: assert property (@(posedge clk) !rstN |=> (!dmValid && !dmWe))
        else begin
            $error("memory request active right after reset");
            resetFails++;
        end

endmodule

bind cpuCore cpuCoreSva i_cpuCoreSva (
    .clk     (clk),
    .rstN    (rstN),
    .dmValid (dmValid),
    .dmWe    (dmWe),
    .dmReady (dmReady),
    .memWait (memWait),
    .pc      (pc)
);

/* cpuCore.sv */
// single cycle core with no branch delay slot and a combinational word addressed instruction port
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuCore (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [4:0]           regAddr,
    output logic [`CPU_XLEN-1:0] regData,
    output logic [`CPU_XLEN-1:0] imAddr,
    input  logic [`CPU_XLEN-1:0] imData,
    output logic [`CPU_XLEN-1:0] dmAddr,
    output logic                 dmWe,
    output logic [`CPU_XLEN-1:0] dmWData,
    output logic                 dmValid,
    input  logic                 dmReady,
    input  logic [`CPU_XLEN-1:0] dmRData
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pcPlus4;
    logic [`CPU_XLEN-1:0] pcBranch;
    logic [`CPU_XLEN-1:0] pcFlow;
    logic [`CPU_XLEN-1:0] pcNext;
    pcSelE                pcSel;
    logic [`CPU_XLEN-1:0] instr;
    logic [`CPU_XLEN-1:0] signImm;
    ctrlWordT             ctrl;
    logic                 riFound;
    logic [`CPU_XLEN-1:0] rdDataA;
    logic [`CPU_XLEN-1:0] rdDataB;
    logic [`CPU_XLEN-1:0] dbgData;
    logic [4:0]           wrAddr;
    logic [`CPU_XLEN-1:0] wrData;
    logic [`CPU_XLEN-1:0] aluSrcB;
    logic [`CPU_XLEN-1:0] aluResult;
    logic                 aluZero;
    logic                 branchTaken;
    logic                 excTaken;
    logic [`CPU_XLEN-1:0] epc;
    logic [`CPU_XLEN-1:0] cpzRData;
    logic                 memWait;      // access issued, waiting for ready
    logic                 memStart;
    logic                 memDone;
    logic                 stall;

    assign instr  = imData;
    assign imAddr = pc >> 2;    // rom is word addressed

    // debug port, register zero slot shows the pc
    assign regData = (regAddr != 5'd0) ? dbgData : pc;

    cpuControl i_cpuControl (
        .opcode  (opcodeE'(instr[31:26])),
        .funct   (functE'(instr[5:0])),
        .rsField (instr[25:21]),
        .ctrl    (ctrl),
        .riFound (riFound)
    );

    assign wrAddr = ctrl.regDst ? instr[15:11] : instr[20:16];

    cpuRegFile i_cpuRegFile (
        .clk     (clk),
        .rdAddrA (instr[25:21]),
        .rdAddrB (instr[20:16]),
        .dbgAddr (regAddr),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .dbgData (dbgData),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (ctrl.regWrite & ~stall)  // lw writes on the ready edge
    );

    assign signImm = {{16{instr[15]}}, instr[15:0]};
    assign aluSrcB = ctrl.aluSrc ? signImm : rdDataB;

    cpuAlu i_cpuAlu (
        .srcA   (rdDataA),
        .srcB   (aluSrcB),
        .op     (ctrl.aluOp),
        .shamt  (instr[10:6]),
        .result (aluResult),
        .zero   (aluZero)
    );

    cpuExcUnit i_cpuExcUnit (
        .clk      (clk),
        .rstN     (rstN),
        .riFound  (riFound),
        .eret     (ctrl.eret),
        .pc       (pc),
        .regNum   (instr[15:11]),
        .regWData (rdDataB),        // mtc0 source is rt
        .regWe    (ctrl.cpzWrite),
        .excTaken (excTaken),
        .epc      (epc),
        .regRData (cpzRData)
    );

    assign wrData = ctrl.memToReg ? dmRData :
                    ctrl.cpzToReg ? cpzRData : aluResult;

    // memory handshake
    assign memStart = ~memWait & ctrl.memAccess;
    assign memDone  = memWait & dmReady;
    assign stall    = memStart | (memWait & ~dmReady);

    assign dmValid = memStart;      // first cycle only
    assign dmWe    = ctrl.memWrite;
    assign dmAddr  = aluResult;
    assign dmWData = rdDataB;

    always_ff @(posedge clk) begin
        if (!rstN)         memWait <= 1'b0;
        else if (memStart) memWait <= 1'b1;
        else if (memDone)  memWait <= 1'b0;
    end

    // next pc
    assign pcPlus4     = pc + 32'd4;
    assign pcBranch    = pcPlus4 + (signImm << 2);
    assign branchTaken = ctrl.branch & (aluZero == ctrl.condZero);
    assign pcFlow      = branchTaken ? pcBranch : pcPlus4;

    always_comb begin
        if (excTaken)       pcSel = PC_EXC;   // trap wins over eret
        else if (ctrl.eret) pcSel = PC_ERET;
        else                pcSel = PC_FLOW;
    end

    always_comb begin
        case (pcSel)
            PC_EXC:  pcNext = `CPU_EXC_HANDLER;
            PC_ERET: pcNext = epc;
            default: pcNext = pcFlow;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)       pc <= `CPU_RESET_PC;
        else if (!stall) pc <= pcNext;
    end

endmodule

/* cpuExcUnit.sv */
// cp0 subset with only epc and a scratch register so a nested trap keeps the outer epc
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuExcUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 riFound,
    input  logic                 eret,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [4:0]           regNum,
    input  logic [`CPU_XLEN-1:0] regWData,
    input  logic                 regWe,
    output logic                 excTaken,
    output logic [`CPU_XLEN-1:0] epc,
    output logic [`CPU_XLEN-1:0] regRData
);
    localparam logic [4:0] scratchNum = 5'd12;
    localparam logic [4:0] epcNum     = 5'd14;

    logic [`CPU_XLEN-1:0] scratch;
    logic                 excLevel;   // inside the handler

    assign excTaken = riFound;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epc      <= '0;
            scratch  <= '0;
            excLevel <= 1'b0;
        end else begin
            if (riFound) begin
                if (!excLevel) epc <= pc;   // pc of the bad instruction
                excLevel <= 1'b1;
            end else begin
                if (eret) excLevel <= 1'b0;
                if (regWe && regNum == epcNum) epc <= regWData;
            end
            if (regWe && regNum == scratchNum) scratch <= regWData;
        end
    end

    // mfc0 read, unknown numbers read zero
    always_comb begin
        case (regNum)
            scratchNum: regRData = scratch;
            epcNum:     regRData = epc;
            default:    regRData = '0;
        endcase
    end

endmodule

/* cpuControl.sv */
// nop is detected from opcode funct and rs only so any sll with rs zero also acts as nop
`timescale 1ns/1ps

module cpuControl (
    input  cpuIsaPkg::opcodeE    opcode,
    input  cpuIsaPkg::functE     funct,
    input  logic [4:0]           rsField,
    output cpuCtrlPkg::ctrlWordT ctrl,
    output logic                 riFound
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    logic isNop;

    assign isNop = (funct == functE'(6'h00)) && (rsField == 5'd0);

    always_comb begin
        ctrl       = '0;      // no writes unless decoded below
        ctrl.aluOp = ALU_ADD;
        riFound    = 1'b0;

        case (opcode)
            OP_SPEC: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    F_ADDU: ctrl.aluOp = ALU_ADD;
                    F_OR:   ctrl.aluOp = ALU_OR;
                    F_SRL:  ctrl.aluOp = ALU_SRL;
                    F_SLTU: ctrl.aluOp = ALU_SLTU;
                    F_SUBU: ctrl.aluOp = ALU_SUBU;
                    default: begin
                        ctrl.regDst   = 1'b0;
                        ctrl.regWrite = 1'b0;
                        riFound       = !isNop;
                    end
                endcase
            end
            OP_ADDIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_LUI;
            end
            OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;  // base + offset
                ctrl.memToReg  = 1'b1;
                ctrl.memAccess = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.memAccess = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch   = 1'b1;
                ctrl.condZero = 1'b1;
                ctrl.aluOp    = ALU_SUBU;
            end
            OP_BNE: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUBU;
            end
            OP_COP0: begin
                case (cop0SubE'(rsField))
                    C0_MF: begin
                        ctrl.cpzToReg = 1'b1;   // result lands in rt
                        ctrl.regWrite = 1'b1;
                    end
                    C0_MT:   ctrl.cpzWrite = 1'b1;
                    C0_CO:   begin
                        if (funct == F_ERET) ctrl.eret = 1'b1;
                        else                 riFound   = 1'b1;
                    end
                    default: riFound = 1'b1;
                endcase
            end
            default: riFound = 1'b1;
        endcase
    end

endmodule

/* cpuAlu.sv */
// pure combinational and unsigned only with no overflow detection
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuAlu (
    input  logic [`CPU_XLEN-1:0] srcA,
    input  logic [`CPU_XLEN-1:0] srcB,
    input  cpuCtrlPkg::aluOpE    op,
    input  logic [4:0]           shamt,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 zero
);
    import cpuCtrlPkg::*;

    always_comb begin
        case (op)
            ALU_ADD:  result = srcA + srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_LUI:  result = srcB << 16;     // immediate to upper half
            ALU_SRL:  result = srcB >> shamt;  // rt shifted, rs unused
            ALU_SLTU: result = {{(`CPU_XLEN-1){1'b0}}, (srcA < srcB)};
            ALU_SUBU: result = srcA - srcB;
            default:  result = srcA + srcB;
        endcase
    end

    // beq/bne compare by subtraction
    assign zero = (result == '0);

endmodule

/* cpuRegFile.sv */
// reads are combinational and a write shows up only after the clock edge so there is no bypass
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuRegFile (
    input  logic                 clk,
    input  logic [4:0]           rdAddrA,
    input  logic [4:0]           rdAddrB,
    input  logic [4:0]           dbgAddr,
    output logic [`CPU_XLEN-1:0] rdDataA,
    output logic [`CPU_XLEN-1:0] rdDataB,
    output logic [`CPU_XLEN-1:0] dbgData,
    input  logic [4:0]           wrAddr,
    input  logic [`CPU_XLEN-1:0] wrData,
    input  logic                 wrEn
);
    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // register zero is hardwired
    assign rdDataA = (rdAddrA != 5'd0) ? regs[rdAddrA] : '0;
    assign rdDataB = (rdAddrB != 5'd0) ? regs[rdAddrB] : '0;
    assign dbgData = (dbgAddr != 5'd0) ? regs[dbgAddr] : '0;

    always_ff @(posedge clk) begin
        if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

/* cpuCtrlPkg.sv */
// decoder output types and the alu op codes are internal and not an isa encoding
package cpuCtrlPkg;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_OR   = 3'd1,
        ALU_LUI  = 3'd2,
        ALU_SRL  = 3'd3,
        ALU_SLTU = 3'd4,
        ALU_SUBU = 3'd5
    } aluOpE;

    // next pc source
    typedef enum logic [1:0] {
        PC_FLOW = 2'd0,     // pc + 4 or branch target
        PC_EXC  = 2'd1,     // trap handler
        PC_ERET = 2'd2      // back to epc
    } pcSelE;

    // one decoded instruction
    typedef struct packed {
        logic  regDst;      // rd instead of rt
        logic  regWrite;
        logic  aluSrc;      // immediate as operand b
        logic  memToReg;
        logic  memWrite;
        logic  memAccess;   // lw or sw
        logic  branch;
        logic  condZero;    // beq takes on zero, bne on nonzero
        logic  cpzToReg;    // mfc0
        logic  cpzWrite;    // mtc0
        logic  eret;
        aluOpE aluOp;
    } ctrlWordT;

endpackage

/* cpuIsaPkg.sv */
// mips32 encodings for the supported subset and every other pattern traps as reserved
package cpuIsaPkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPEC  = 6'h00,   // funct selects the op
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_COP0  = 6'h10,   // rs selects the subop
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    // function code, instr[5:0]
    typedef enum logic [5:0] {
        F_SRL  = 6'h02,
        F_ERET = 6'h18,     // only with OP_COP0 and C0_CO
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_OR   = 6'h25,
        F_SLTU = 6'h2b
    } functE;

    // coprocessor 0 subop in the rs field
    typedef enum logic [4:0] {
        C0_MF = 5'h00,
        C0_MT = 5'h04,
        C0_CO = 5'h10
    } cop0SubE;

endpackage

/* cpu_defs.svh */
// shared sizes and addresses for rtl and testbench and the decode only supports a 32 bit width
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath width, also the address width
`define CPU_XLEN 32

// general purpose registers
`define CPU_NREGS 32

// first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// reserved instruction trap target (word 64 of the program rom)
`define CPU_EXC_HANDLER 32'h0000_0100

`endif
